//--- source/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    // word addressed bank, byte lanes within a word
    localparam int ADDR_W = 10;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;  // word address
    typedef logic [DATA_W-1:0] word_t;  // one data word
    typedef logic [BE_W-1:0]   be_t;    // byte enables, active high

    // top level default bank size, fills the whole address space
    localparam int MEM_WORDS_DEF = 1024;

endpackage

`default_nettype wire

//--- source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // fetch entry is just the word address
    localparam int FETCH_ENTRY_W = mem_map_pkg::ADDR_W;

    // load/store entry, msb first: we | be | wdata | addr
    localparam int LSU_ADDR_LSB = 0;
    localparam int LSU_DATA_LSB = LSU_ADDR_LSB + mem_map_pkg::ADDR_W;
    localparam int LSU_BE_LSB   = LSU_DATA_LSB + mem_map_pkg::DATA_W;
    localparam int LSU_WE_BIT   = LSU_BE_LSB + mem_map_pkg::BE_W;
    localparam int LSU_ENTRY_W  = LSU_WE_BIT + 1;  // 47 bits

    typedef logic [FETCH_ENTRY_W-1:0] fetch_entry_t;
    typedef logic [LSU_ENTRY_W-1:0]   lsu_entry_t;

    // owner of the read in flight, steers next cycle's rdata
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_FETCH,
        GRANT_LSU
    } grant_e;

endpackage

`default_nettype wire

//--- source/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic               req;    // access this cycle
    logic               we;     // low means read
    mem_map_pkg::addr_t addr;
    mem_map_pkg::be_t   be;
    mem_map_pkg::word_t wdata;
    mem_map_pkg::word_t rdata;  // valid the cycle after a read

    modport master (
        output req, we, addr, be, wdata,
        input  rdata
    );

    modport slave (
        input  req, we, addr, be, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- source/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter int DEPTH   = 4,
    parameter int ENTRY_W = 8
) (
    input  wire               clk_i,
    input  wire               locked_i,
    input  wire               push_i,
    input  wire [ENTRY_W-1:0] push_data_i,
    input  wire               pop_i,
    output logic              not_empty_o,
    output logic [ENTRY_W-1:0] head_o,
    output logic              credit_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;  // occupancy, sender's credits keep it <= DEPTH

    // storage, payload only
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_o <= pop_i;  // one credit back per freed slot
        end
    end

    assign not_empty_o = (count != '0);
    assign head_o      = mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire                    clk_i,
    input  wire                    locked_i,
    input  wire                    fetch_pending_i,
    input  wire bus_pkg::fetch_entry_t fetch_head_i,
    input  wire                    lsu_pending_i,
    input  wire bus_pkg::lsu_entry_t   lsu_head_i,
    output logic                   fetch_pop_o,
    output logic                   lsu_pop_o,
    output logic                   fetch_rvalid_o,
    output mem_map_pkg::word_t     fetch_rdata_o,
    output logic                   lsu_rvalid_o,
    output mem_map_pkg::word_t     lsu_rdata_o,
    mem_bus_if.master              bus
);

    logic                lsu_we;
    mem_map_pkg::be_t    lsu_be;
    mem_map_pkg::word_t  lsu_wdata;
    mem_map_pkg::addr_t  lsu_addr;
    logic                grant_fetch;
    logic                grant_lsu;
    bus_pkg::grant_e     grant_d;
    bus_pkg::grant_e     grant_q;

    // unpack the load/store head
    assign lsu_we    = lsu_head_i[bus_pkg::LSU_WE_BIT];
    assign lsu_be    = lsu_head_i[bus_pkg::LSU_BE_LSB +: mem_map_pkg::BE_W];
    assign lsu_wdata = lsu_head_i[bus_pkg::LSU_DATA_LSB +: mem_map_pkg::DATA_W];
    assign lsu_addr  = lsu_head_i[bus_pkg::LSU_ADDR_LSB +: mem_map_pkg::ADDR_W];

    // load/store always wins, fetch only gets idle cycles
    assign grant_lsu   = lsu_pending_i;
    assign grant_fetch = fetch_pending_i & ~lsu_pending_i;

    assign lsu_pop_o   = grant_lsu;
    assign fetch_pop_o = grant_fetch;

    // drive the shared bus from the winner's head
    assign bus.req   = grant_lsu | grant_fetch;
    assign bus.we    = grant_lsu & lsu_we;  // fetch never writes
    assign bus.addr  = grant_lsu ? lsu_addr : mem_map_pkg::addr_t'(fetch_head_i);
    assign bus.be    = grant_lsu ? lsu_be : '1;
    assign bus.wdata = lsu_wdata;

    always_comb begin
        if (grant_lsu && !lsu_we) begin
            grant_d = bus_pkg::GRANT_LSU;
        end else if (grant_fetch) begin
            grant_d = bus_pkg::GRANT_FETCH;
        end else begin
            grant_d = bus_pkg::GRANT_NONE;  // idle or store, no response
        end
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            grant_q <= bus_pkg::GRANT_NONE;
        end else begin
            grant_q <= grant_d;
        end
    end

    // bank data lands one cycle after the grant
    assign fetch_rvalid_o = (grant_q == bus_pkg::GRANT_FETCH);
    assign lsu_rvalid_o   = (grant_q == bus_pkg::GRANT_LSU);
    assign fetch_rdata_o  = bus.rdata;
    assign lsu_rdata_o    = bus.rdata;

endmodule

`default_nettype wire

//--- source/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
    parameter int MEM_WORDS = 1024
) (
    input  wire       clk_i,
    mem_bus_if.slave  bus
);

    localparam int BYTES = mem_map_pkg::BE_W;

    mem_map_pkg::word_t mem [MEM_WORDS];

    // write only the enabled lanes
    always_ff @(posedge clk_i) begin
        if (bus.req && bus.we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (bus.be[b]) begin
                    mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk_i) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= mem[bus.addr];
        end
    end

endmodule

`default_nettype wire

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int DEPTH     = 4,
    parameter int MEM_WORDS = mem_map_pkg::MEM_WORDS_DEF
) (
    input  wire                     clk_i,
    input  wire                     locked_i,
    // fetch port, read only
    input  wire                     fetch_valid_i,
    input  wire mem_map_pkg::addr_t fetch_addr_i,
    output logic                    fetch_credit_o,
    output logic                    fetch_rvalid_o,
    output mem_map_pkg::word_t      fetch_rdata_o,
    // load/store port
    input  wire                     lsu_valid_i,
    input  wire                     lsu_we_i,
    input  wire mem_map_pkg::be_t   lsu_be_i,
    input  wire mem_map_pkg::addr_t lsu_addr_i,
    input  wire mem_map_pkg::word_t lsu_wdata_i,
    output logic                    lsu_credit_o,
    output logic                    lsu_rvalid_o,
    output mem_map_pkg::word_t      lsu_rdata_o
);

    bus_pkg::fetch_entry_t fetch_head;
    logic                  fetch_not_empty;
    logic                  fetch_pop;
    bus_pkg::lsu_entry_t   lsu_push_entry;
    bus_pkg::lsu_entry_t   lsu_head;
    logic                  lsu_not_empty;
    logic                  lsu_pop;

    mem_bus_if u_bus ();

    // pack the load/store request
    assign lsu_push_entry[bus_pkg::LSU_WE_BIT] = lsu_we_i;
    assign lsu_push_entry[bus_pkg::LSU_BE_LSB +: mem_map_pkg::BE_W] = lsu_be_i;
    assign lsu_push_entry[bus_pkg::LSU_DATA_LSB +: mem_map_pkg::DATA_W] = lsu_wdata_i;
    assign lsu_push_entry[bus_pkg::LSU_ADDR_LSB +: mem_map_pkg::ADDR_W] = lsu_addr_i;

    req_queue #(
        .DEPTH   (DEPTH),
        .ENTRY_W (bus_pkg::FETCH_ENTRY_W)
    ) u_fetch_queue (
        .clk_i       (clk_i),
        .locked_i    (locked_i),
        .push_i      (fetch_valid_i),
        .push_data_i (fetch_addr_i),
        .pop_i       (fetch_pop),
        .not_empty_o (fetch_not_empty),
        .head_o      (fetch_head),
        .credit_o    (fetch_credit_o)
    );

    req_queue #(
        .DEPTH   (DEPTH),
        .ENTRY_W (bus_pkg::LSU_ENTRY_W)
    ) u_lsu_queue (
        .clk_i       (clk_i),
        .locked_i    (locked_i),
        .push_i      (lsu_valid_i),
        .push_data_i (lsu_push_entry),
        .pop_i       (lsu_pop),
        .not_empty_o (lsu_not_empty),
        .head_o      (lsu_head),
        .credit_o    (lsu_credit_o)
    );

    bus_arbiter u_arbiter (
        .clk_i           (clk_i),
        .locked_i        (locked_i),
        .fetch_pending_i (fetch_not_empty),
        .fetch_head_i    (fetch_head),
        .lsu_pending_i   (lsu_not_empty),
        .lsu_head_i      (lsu_head),
        .fetch_pop_o     (fetch_pop),
        .lsu_pop_o       (lsu_pop),
        .fetch_rvalid_o  (fetch_rvalid_o),
        .fetch_rdata_o   (fetch_rdata_o),
        .lsu_rvalid_o    (lsu_rvalid_o),
        .lsu_rdata_o     (lsu_rdata_o),
        .bus             (u_bus.master)
    );

    sram_bank #(
        .MEM_WORDS (MEM_WORDS)
    ) u_bank (
        .clk_i (clk_i),
        .bus   (u_bus.slave)
    );

endmodule

`default_nettype wire

//--- test/mem_subsys_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_properties #(
    parameter int DEPTH = 4
) (
    input wire clk_i,
    input wire locked_i,
    input wire fetch_push_i,
    input wire fetch_pop_i,
    input wire lsu_push_i,
    input wire lsu_pop_i,
    input wire lsu_head_we_i,
    input wire fetch_rvalid_i,
    input wire lsu_rvalid_i
);

    int fetch_occ;  // shadow occupancy of each queue
    int lsu_occ;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            fetch_occ <= 0;
            lsu_occ   <= 0;
        end else begin
            fetch_occ <= fetch_occ + int'(fetch_push_i) - int'(fetch_pop_i);
            lsu_occ   <= lsu_occ + int'(lsu_push_i) - int'(lsu_pop_i);
        end
    end

    fetch_no_overflow: assert property (@(posedge clk_i) disable iff (!locked_i)
        fetch_push_i |-> fetch_occ < DEPTH) else $error("push into full fetch queue");
    lsu_no_overflow: assert property (@(posedge clk_i) disable iff (!locked_i)
        lsu_push_i |-> lsu_occ < DEPTH) else $error("push into full lsu queue");

    // read data only follows a read grant
    fetch_rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!locked_i)
        fetch_rvalid_i |-> $past(fetch_pop_i)) else $error("fetch rvalid without grant");
    lsu_rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!locked_i)
        lsu_rvalid_i |-> $past(lsu_pop_i && !lsu_head_we_i))
        else $error("lsu rvalid without load grant");
    rvalid_one_hot: assert property (@(posedge clk_i) disable iff (!locked_i)
        !(fetch_rvalid_i && lsu_rvalid_i)) else $error("both response valids high");

endmodule

bind mem_subsys_top mem_subsys_properties #(
    .DEPTH (DEPTH)
) u_props (
    .clk_i          (clk_i),
    .locked_i       (locked_i),
    .fetch_push_i   (fetch_valid_i),
    .fetch_pop_i    (fetch_pop),
    .lsu_push_i     (lsu_valid_i),
    .lsu_pop_i      (lsu_pop),
    .lsu_head_we_i  (lsu_head[bus_pkg::LSU_WE_BIT]),
    .fetch_rvalid_i (fetch_rvalid_o),
    .lsu_rvalid_i   (lsu_rvalid_o)
);

`default_nettype wire

//--- test/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int   DEPTH          = 4;
    localparam int   CLK_PERIOD     = 10;
    localparam int   RESET_CYCLES   = 5;
    localparam int   N_ROWS         = 35;
    localparam int   TIMEOUT_CYCLES = N_ROWS * 50 + RESET_CYCLES;
    localparam logic PORT_FETCH     = 1'b0;
    localparam logic PORT_LSU       = 1'b1;

    logic               clk_i = 1'b0;
    logic               locked_i;
    logic               fetch_valid_i;
    mem_map_pkg::addr_t fetch_addr_i;
    logic               fetch_credit_o;
    logic               fetch_rvalid_o;
    mem_map_pkg::word_t fetch_rdata_o;
    logic               lsu_valid_i;
    logic               lsu_we_i;
    mem_map_pkg::be_t   lsu_be_i;
    mem_map_pkg::addr_t lsu_addr_i;
    mem_map_pkg::word_t lsu_wdata_i;
    logic               lsu_credit_o;
    logic               lsu_rvalid_o;
    mem_map_pkg::word_t lsu_rdata_o;

    // stimulus table with one request per row
    logic               row_port  [N_ROWS];
    logic               row_we    [N_ROWS];
    mem_map_pkg::be_t   row_be    [N_ROWS];
    mem_map_pkg::addr_t row_addr  [N_ROWS];
    mem_map_pkg::word_t row_wdata [N_ROWS];
    logic               row_resp  [N_ROWS];  // read that expects data back
    int                 n_rows = 0;

    mem_map_pkg::word_t model_mem [mem_map_pkg::MEM_WORDS_DEF];
    mem_map_pkg::word_t fetch_exp [$];  // expected read data in issue order
    mem_map_pkg::word_t lsu_exp   [$];
    int                 seed          = 21983;
    int                 fetch_credits = DEPTH;
    int                 lsu_credits   = DEPTH;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    mem_subsys_top #(
        .DEPTH (DEPTH)
    ) u_dut (
        .clk_i          (clk_i),
        .locked_i       (locked_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_credit_o (fetch_credit_o),
        .fetch_rvalid_o (fetch_rvalid_o),
        .fetch_rdata_o  (fetch_rdata_o),
        .lsu_valid_i    (lsu_valid_i),
        .lsu_we_i       (lsu_we_i),
        .lsu_be_i       (lsu_be_i),
        .lsu_addr_i     (lsu_addr_i),
        .lsu_wdata_i    (lsu_wdata_i),
        .lsu_credit_o   (lsu_credit_o),
        .lsu_rvalid_o   (lsu_rvalid_o),
        .lsu_rdata_o    (lsu_rdata_o)
    );

    task automatic check_value(input mem_map_pkg::word_t actual,
                               input mem_map_pkg::word_t expected, input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_row(input logic port, input logic we, input mem_map_pkg::be_t be,
                           input int addr);
        row_port[n_rows]  = port;
        row_we[n_rows]    = we;
        row_be[n_rows]    = be;
        row_addr[n_rows]  = mem_map_pkg::addr_t'(addr);
        row_wdata[n_rows] = $random(seed);
        row_resp[n_rows]  = !we;  // stores only return a credit
        n_rows++;
    endtask

    task automatic build_table();
        add_row(PORT_LSU, 1'b1, 4'hf, 'h010);  // full store then load
        add_row(PORT_LSU, 1'b0, 4'hf, 'h010);
        add_row(PORT_LSU, 1'b1, 4'hf, 'h020);
        add_row(PORT_LSU, 1'b1, 4'b0101, 'h020);  // partial merge
        add_row(PORT_LSU, 1'b0, 4'hf, 'h020);
        add_row(PORT_LSU, 1'b1, 4'hf, 'h021);
        add_row(PORT_LSU, 1'b1, 4'b1010, 'h021);
        add_row(PORT_LSU, 1'b1, 4'b0001, 'h021);
        // fetch back what was stored
        add_row(PORT_FETCH, 1'b0, 4'hf, 'h010);
        add_row(PORT_FETCH, 1'b0, 4'hf, 'h020);
        add_row(PORT_FETCH, 1'b0, 4'hf, 'h021);
        for (int i = 0; i < 8; i++) begin
            add_row(PORT_LSU, 1'b1, 4'hf, 'h100 + i);
        end
        // both ports at full rate so fetch starves behind load/store
        for (int i = 0; i < 8; i++) begin
            add_row(PORT_FETCH, 1'b0, 4'hf, 'h100 + i);
            add_row(PORT_LSU, 1'b0, 4'hf, 'h107 - i);
        end
        check_value(n_rows, N_ROWS, "stimulus table size");
    endtask

    task automatic issue_row(input int r);
        mem_map_pkg::addr_t a;
        a = row_addr[r];
        if (row_port[r] == PORT_LSU) begin
            lsu_valid_i = 1'b1;
            lsu_we_i    = row_we[r];
            lsu_be_i    = row_be[r];
            lsu_addr_i  = a;
            lsu_wdata_i = row_wdata[r];
            lsu_credits--;
        end else begin
            fetch_valid_i = 1'b1;
            fetch_addr_i  = a;
            fetch_credits--;
        end
        // reference model applies a store at issue time
        if (row_we[r]) begin
            for (int b = 0; b < mem_map_pkg::BE_W; b++) begin
                if (row_be[r][b]) begin
                    model_mem[a][8*b +: 8] = row_wdata[r][8*b +: 8];
                end
            end
        end else if (row_resp[r] && row_port[r] == PORT_LSU) begin
            lsu_exp.push_back(model_mem[a]);
        end else if (row_resp[r]) begin
            fetch_exp.push_back(model_mem[a]);
        end
    endtask

    // one clock then look at the registered outputs
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
        fetch_valid_i = 1'b0;
        lsu_valid_i   = 1'b0;
        if (fetch_credit_o) begin
            fetch_credits++;
            check_value(32'(fetch_credits <= DEPTH), 32'd1, "fetch credit with none spent");
        end
        if (lsu_credit_o) begin
            lsu_credits++;
            check_value(32'(lsu_credits <= DEPTH), 32'd1, "lsu credit with none spent");
        end
        if (fetch_rvalid_o) begin
            check_value(32'(fetch_exp.size() > 0), 32'd1, "fetch response with no read open");
            check_value(fetch_rdata_o, fetch_exp.pop_front(), "fetch read data");
        end
        if (lsu_rvalid_o) begin
            check_value(32'(lsu_exp.size() > 0), 32'd1, "lsu response with no load open");
            check_value(lsu_rdata_o, lsu_exp.pop_front(), "lsu read data");
        end
    endtask

    initial begin
        int   next_row;
        logic fetch_used;
        logic lsu_used;
        locked_i      = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        lsu_valid_i   = 1'b0;
        lsu_we_i      = 1'b0;
        lsu_be_i      = '0;
        lsu_addr_i    = '0;
        lsu_wdata_i   = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        locked_i = 1'b1;
        repeat (4) begin  // quiet outputs before any request
            step_cycle();
            check_value(32'({fetch_credit_o, fetch_rvalid_o, lsu_credit_o, lsu_rvalid_o}),
                        32'd0, "credit or valid high while idle");
        end
        next_row = 0;
        while (next_row < N_ROWS) begin
            step_cycle();
            fetch_used = 1'b0;
            lsu_used   = 1'b0;
            repeat (2) begin  // up to one row per port each cycle
                if (next_row < N_ROWS) begin
                    if (row_port[next_row] == PORT_LSU && !lsu_used && lsu_credits > 0) begin
                        issue_row(next_row);
                        lsu_used = 1'b1;
                        next_row++;
                    end else if (row_port[next_row] == PORT_FETCH && !fetch_used &&
                                 fetch_credits > 0) begin
                        issue_row(next_row);
                        fetch_used = 1'b1;
                        next_row++;
                    end
                end
            end
        end
        while (fetch_exp.size() > 0 || lsu_exp.size() > 0 ||
               fetch_credits != DEPTH || lsu_credits != DEPTH) begin
            step_cycle();
        end
        // no stray credit or response once everything has drained
        repeat (2 * DEPTH) begin
            step_cycle();
            check_value(32'({fetch_credit_o, fetch_rvalid_o, lsu_credit_o, lsu_rvalid_o}),
                        32'd0, "credit or valid high after drain");
        end
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: responses or credits did not return within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- filelist.f
source/mem_map_pkg.sv
source/bus_pkg.sv
source/mem_bus_if.sv
source/req_queue.sv
source/bus_arbiter.sv
source/sram_bank.sv
source/mem_subsys_top.sv
test/mem_subsys_properties.sv
test/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsys -f filelist.f -o Vtb_mem_subsys

# the pipe status is tee's, so a fatal stop still reaches the log search
./obj_dir/Vtb_mem_subsys | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi
